//--- src.f
+incdir+.
cpu_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
mem_unit.sv
hazard_ctrl.sv
cpu_top.sv
tb_clk_gen.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_cpu;

    localparam int ROM_WORDS  = 64;
    localparam int WAIT_LIMIT = 50;         // cycles for reset and first fetch
    localparam int RUN_LIMIT  = 2000;       // cycles for the whole program

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] val;
    } retire_t;

    typedef struct packed {
        logic        st;                    // 1 store, 0 load
        logic [31:0] addr;
        logic [31:0] data;                  // store data only
    } bus_t;

    logic        cpu_clk, cpu_rstn;
    logic        ifetch_rreq;
    logic [31:0] ifetch_addr, ifetch_inst, rom_idx;
    logic [3:0]  daccess_ren, daccess_wen;
    logic [31:0] daccess_addr, daccess_wdata, daccess_rdata;
    logic        daccess_valid, daccess_wresp;
    logic [31:0] debug_wb_pc, debug_wb_value;
    logic [3:0]  debug_wb_ena;
    logic [4:0]  debug_wb_reg;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] dmem [256];
    retire_t     exp_q [$];                 // golden retirements in order
    bus_t        bus_q [$];                 // golden data accesses in order

    tb_clk_gen u_clk (.cpu_clk, .cpu_rstn);

    cpu_top UUT (
        .cpu_clk, .cpu_rstn, .ifetch_rreq, .ifetch_addr, .ifetch_inst,
        .daccess_ren, .daccess_wen, .daccess_addr, .daccess_wdata,
        .daccess_valid, .daccess_rdata, .daccess_wresp,
        .debug_wb_pc, .debug_wb_ena, .debug_wb_reg, .debug_wb_value
    );

    // combinational fetch port, zero word decodes as a no-op
    assign rom_idx     = (ifetch_addr - `CPU_RESET_PC) >> 2;
    assign ifetch_inst = (rom_idx < ROM_WORDS) ? rom[rom_idx] : 32'h0;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAIL %s expected %h actual %h", name, exp, act);
        abort_run();
    endtask

    task automatic wait_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_3ca5;  // whole byte address
    endfunction

    // instruction encoders
    function automatic logic [31:0] op_r(input logic [16:0] op, input logic [4:0] rd,
                                         input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] op_i(input logic [9:0] op, input logic [4:0] rd,
                                         input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] op_br(input logic [5:0] op, input logic [4:0] rj,
                                          input logic [4:0] rd, input logic [15:0] offs);
        return {op, offs, rj, rd};          // offs in words
    endfunction

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = 32'h0;
        rom[0]  = {`OP_LU12I_W, 20'h12345, 5'd1};
        rom[1]  = op_i(`OP_ADDI_W, 1, 1, 12'h678);     // EX forward
        rom[2]  = op_i(`OP_ADDI_W, 2, 0, -12'sd5);
        rom[3]  = op_r(`OP_ADD_W, 3, 1, 2);             // EX and MEM
        rom[4]  = op_r(`OP_SUB_W, 4, 3, 1);             // r1 from WB
        rom[5]  = op_r(`OP_AND, 5, 4, 3);
        rom[6]  = op_r(`OP_OR, 6, 5, 2);
        rom[7]  = op_r(`OP_XOR, 7, 6, 1);
        rom[8]  = op_r(`OP_SLT, 8, 2, 7);
        rom[9]  = op_r(`OP_SLT, 9, 7, 8);
        rom[10] = op_i(`OP_ADDI_W, 10, 0, 12'h100);     // data base
        rom[11] = op_i(`OP_ST_W, 7, 10, 12'h000);
        rom[12] = op_i(`OP_LD_W, 11, 10, 12'h000);      // reads the store back
        rom[13] = op_r(`OP_ADD_W, 12, 11, 1);           // load-use
        rom[14] = op_i(`OP_LD_W, 13, 10, 12'h008);
        rom[15] = op_i(`OP_ADDI_W, 14, 13, 12'h001);    // load-use again
        rom[16] = op_i(`OP_LD_W, 3, 10, 12'h002);       // misaligned, r3 kept
        rom[17] = op_i(`OP_ADDI_W, 0, 0, 12'h005);      // r0 write, not shown
        rom[18] = op_r(`OP_ADD_W, 16, 3, 14);
        rom[19] = op_br(`OP_BEQ, 1, 1, 16'd3);          // taken
        rom[20] = op_i(`OP_ADDI_W, 20, 0, 12'h001);     // sentinel
        rom[21] = op_i(`OP_ADDI_W, 20, 0, 12'h002);
        rom[22] = op_br(`OP_BNE, 1, 2, 16'd3);          // taken
        rom[23] = op_i(`OP_ADDI_W, 20, 0, 12'h003);
        rom[24] = op_i(`OP_ADDI_W, 20, 0, 12'h004);
        rom[25] = {`OP_B, 16'd3, 10'd0};                // b +3
        rom[26] = op_i(`OP_ADDI_W, 20, 0, 12'h005);
        rom[27] = op_i(`OP_ADDI_W, 20, 0, 12'h006);
        rom[28] = op_br(`OP_BEQ, 1, 2, 16'd3);          // falls through
        rom[29] = op_i(`OP_ADDI_W, 17, 0, 12'h7ff);
        rom[30] = op_br(`OP_BNE, 17, 17, 16'd3);        // falls through
        rom[31] = op_i(`OP_ADDI_W, 18, 17, -12'sd1);
        rom[32] = op_i(`OP_ADDI_W, 19, 0, 12'h7fe);
        rom[33] = op_br(`OP_BEQ, 19, 18, 16'd3);        // forwarded operands
        rom[34] = op_i(`OP_ADDI_W, 20, 0, 12'h007);
        rom[35] = op_i(`OP_ADDI_W, 20, 0, 12'h008);
        rom[36] = op_i(`OP_ST_W, 18, 0, 12'h104);
        rom[37] = op_i(`OP_LD_W, 22, 0, 12'h104);
        rom[38] = op_r(`OP_XOR, 23, 22, 19);
        rom[39] = {`OP_B, 26'd0};                       // self-loop
    endtask

    // in-order ISA model, fills exp_q and bus_q
    function automatic void run_golden();
        logic [31:0] gr [32];
        logic [31:0] gmem [256];
        logic [31:0] pc, ins, nxt, a, b, si12, val, addr;
        logic [4:0]  rd;
        logic        wr;
        retire_t     r;
        bus_t        acc;
        for (int i = 0; i < 32; i++)
            gr[i] = 32'h0;
        for (int i = 0; i < 256; i++)
            gmem[i] = fill_word(i * 4);
        pc = `CPU_RESET_PC;
        for (int steps = 0; steps < 500; steps++) begin
            ins  = rom[(pc - `CPU_RESET_PC) >> 2];
            rd   = ins[4:0];
            a    = gr[ins[9:5]];
            b    = gr[ins[14:10]];
            si12 = {{20{ins[21]}}, ins[21:10]};
            nxt  = pc + 32'd4;
            wr   = 1'b0;
            val  = 32'h0;
            if (ins[31:26] == `OP_B) begin
                if ({ins[9:0], ins[25:10]} == 26'd0)
                    break;                              // end of program
                nxt = pc + {{4{ins[9]}}, ins[9:0], ins[25:10], 2'b00};
            end else if (ins[31:26] == `OP_BEQ || ins[31:26] == `OP_BNE) begin
                if ((a == gr[rd]) == (ins[31:26] == `OP_BEQ))
                    nxt = pc + {{14{ins[25]}}, ins[25:10], 2'b00};
            end else if (ins[31:25] == `OP_LU12I_W) begin
                wr  = 1'b1;
                val = {ins[24:5], 12'd0};
            end else if (ins[31:22] == `OP_ADDI_W) begin
                wr  = 1'b1;
                val = a + si12;
            end else if (ins[31:22] == `OP_LD_W) begin
                addr = a + si12;
                if (addr[1:0] == 2'b00) begin           // misaligned does nothing
                    wr  = 1'b1;
                    val = gmem[addr[9:2]];
                    acc = {1'b0, addr, 32'h0};
                    bus_q.push_back(acc);
                end
            end else if (ins[31:22] == `OP_ST_W) begin
                addr = a + si12;
                if (addr[1:0] == 2'b00) begin
                    gmem[addr[9:2]] = gr[rd];
                    acc = {1'b1, addr, gr[rd]};
                    bus_q.push_back(acc);
                end
            end else begin
                wr = 1'b1;
                case (ins[31:15])
                    `OP_ADD_W: val = a + b;
                    `OP_SUB_W: val = a - b;
                    `OP_AND:   val = a & b;
                    `OP_OR:    val = a | b;
                    `OP_XOR:   val = a ^ b;
                    `OP_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:   wr = 1'b0;               // no-op
                endcase
            end
            if (wr && rd != 5'd0) begin
                gr[rd] = val;
                r = {pc, rd, val};
                exp_q.push_back(r);
            end
            pc = nxt;
        end
    endfunction

    // data memory, answers after 0 to 3 cycles
    initial begin : mem_model
        bus_t        exp_b;
        logic        is_st;
        int unsigned delay;
        void'($urandom(32'h6d384455));                  // delays drawn in this process
        daccess_valid = 1'b0;
        daccess_wresp = 1'b0;
        daccess_rdata = 32'h0;
        forever begin
            @(negedge cpu_clk);
            daccess_valid = 1'b0;                       // one-cycle pulse
            daccess_wresp = 1'b0;
            if (cpu_rstn === 1'b1 && (daccess_ren != 4'h0 || daccess_wen != 4'h0)) begin
                is_st = (daccess_wen == 4'hf);
                if (!((daccess_ren == 4'hf && daccess_wen == 4'h0)
                      || (daccess_ren == 4'h0 && daccess_wen == 4'hf))) begin
                    $display("bad data request, ren %h wen %h", daccess_ren, daccess_wen);
                    abort_run();
                end else if (bus_q.size() == 0) begin
                    $display("unexpected data access at address %h", daccess_addr);
                    abort_run();
                end else begin
                    exp_b = bus_q.pop_front();
                    assert (is_st == exp_b.st)
                        else fail_value("access kind", exp_b.st, is_st);
                    assert (daccess_addr == exp_b.addr)
                        else fail_value("access address", exp_b.addr, daccess_addr);
                    if (is_st)
                        assert (daccess_wdata == exp_b.data)
                            else fail_value("store data", exp_b.data, daccess_wdata);
                    delay = $urandom % 4;
                    repeat (delay) @(negedge cpu_clk);
                    if (is_st) begin
                        dmem[daccess_addr[9:2]] = daccess_wdata;
                        daccess_wresp = 1'b1;
                    end else begin
                        daccess_rdata = dmem[daccess_addr[9:2]];
                        daccess_valid = 1'b1;
                    end
                end
            end
        end
    end

    // every debug pulse against the golden queue head
    always @(negedge cpu_clk) begin : retire_check
        retire_t exp_r;
        if (cpu_rstn === 1'b1 && debug_wb_ena != 4'h0) begin
            assert (debug_wb_ena == 4'hf)
                else fail_value("debug_wb_ena", 32'hf, debug_wb_ena);
            if (exp_q.size() == 0) begin
                $display("extra retirement at pc %h, reg %0d", debug_wb_pc, debug_wb_reg);
                abort_run();
            end else begin
                exp_r = exp_q.pop_front();
                assert (debug_wb_pc == exp_r.pc)
                    else fail_value("retire pc", exp_r.pc, debug_wb_pc);
                assert (debug_wb_reg == exp_r.rd)
                    else fail_value("retire reg", exp_r.rd, debug_wb_reg);
                assert (debug_wb_value == exp_r.val)
                    else fail_value("retire value", exp_r.val, debug_wb_value);
            end
        end
    end

    initial begin : main
        int cycles;
        load_program();
        for (int i = 0; i < 256; i++)
            dmem[i] = fill_word(i * 4);
        run_golden();

        // outputs quiet through reset
        cycles = 0;
        while (cpu_rstn !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge cpu_clk);
            assert (daccess_ren == 4'h0) else fail_value("reset ren", 0, daccess_ren);
            assert (daccess_wen == 4'h0) else fail_value("reset wen", 0, daccess_wen);
            assert (debug_wb_ena == 4'h0) else fail_value("reset wb_ena", 0, debug_wb_ena);
            if (cpu_rstn !== 1'b1)
                assert (ifetch_rreq == 1'b0) else fail_value("reset rreq", 0, ifetch_rreq);
            cycles++;
        end
        if (cpu_rstn !== 1'b1)
            wait_timeout("reset release");

        cycles = 0;
        while (ifetch_rreq !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge cpu_clk);
            cycles++;
        end
        if (ifetch_rreq !== 1'b1)
            wait_timeout("first fetch");
        assert (ifetch_addr == `CPU_RESET_PC)
            else fail_value("first fetch address", `CPU_RESET_PC, ifetch_addr);

        cycles = 0;
        while (exp_q.size() != 0 && cycles < RUN_LIMIT) begin
            @(negedge cpu_clk);
            cycles++;
        end
        if (exp_q.size() != 0)
            wait_timeout("all retirements");
        repeat (20) @(negedge cpu_clk);     // spinning in the self-loop, nothing else retires

        if (bus_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("%0d data accesses never reached the bus", bus_q.size());
            abort_run();
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic cpu_clk,
    output logic cpu_rstn
);

    initial begin
        cpu_clk = 1'b0;
        forever #5 cpu_clk = ~cpu_clk;      // 10 ns period
    end

    // reset low for three cycles, released on a falling edge
    initial begin
        cpu_rstn = 1'b0;
        repeat (3) @(posedge cpu_clk);
        @(negedge cpu_clk);
        cpu_rstn = 1'b1;
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_top (
    input  logic             cpu_clk,
    input  logic             cpu_rstn,
    output logic             ifetch_rreq,
    output logic [`XLEN-1:0] ifetch_addr,
    input  logic [`XLEN-1:0] ifetch_inst,
    output logic [3:0]       daccess_ren,
    output logic [3:0]       daccess_wen,
    output logic [`XLEN-1:0] daccess_addr,
    output logic [`XLEN-1:0] daccess_wdata,
    input  logic             daccess_valid,
    input  logic [`XLEN-1:0] daccess_rdata,
    input  logic             daccess_wresp,
    output logic [`XLEN-1:0] debug_wb_pc,
    output logic [3:0]       debug_wb_ena,
    output logic [4:0]       debug_wb_reg,
    output logic [`XLEN-1:0] debug_wb_value
);
    import cpu_pkg::*;

    logic             if_id_valid;
    logic [`XLEN-1:0] if_id_pc;
    inst_u            if_id_inst;
    id_ex_t           id_ex;
    ex_mem_t          ex_mem;
    mem_wb_t          wb;
    logic [4:0]       rs1, rs2;
    logic             rs1_re, rs2_re;
    fwd_sel_e         fwd1_sel, fwd2_sel;
    logic             stall_if_id, hold_all, flush_young;
    logic             br_taken, mem_wait;
    logic [`XLEN-1:0] br_target, ex_fwd, mem_fwd;

    fetch_unit u_fetch (
        .cpu_clk, .cpu_rstn,
        .stall(stall_if_id), .hold(hold_all), .flush(flush_young),
        .br_taken, .br_target, .ifetch_inst, .ifetch_rreq, .ifetch_addr,
        .if_id_valid, .if_id_pc, .if_id_inst
    );

    decode_unit u_decode (
        .cpu_clk, .cpu_rstn, .if_id_valid, .if_id_pc, .if_id_inst,
        .stall(stall_if_id), .hold(hold_all), .flush(flush_young),
        .fwd1_sel, .fwd2_sel, .ex_fwd, .mem_fwd, .wb,
        .rs1, .rs2, .rs1_re, .rs2_re, .id_ex
    );

    execute_unit u_execute (
        .cpu_clk, .cpu_rstn, .id_ex, .hold(hold_all),
        .br_taken, .br_target, .ex_fwd, .ex_mem
    );

    mem_unit u_mem (
        .cpu_clk, .cpu_rstn, .ex_mem, .hold(hold_all),
        .daccess_ren, .daccess_wen, .daccess_addr, .daccess_wdata,
        .daccess_valid, .daccess_rdata, .daccess_wresp,
        .mem_wait, .mem_fwd, .wb,
        .debug_wb_pc, .debug_wb_ena, .debug_wb_reg, .debug_wb_value
    );

    hazard_ctrl u_hazard (
        .rs1, .rs2, .rs1_re, .rs2_re, .id_ex, .ex_mem, .wb,
        .mem_wait, .br_taken, .fwd1_sel, .fwd2_sel,
        .stall_if_id, .hold_all, .flush_young
    );

endmodule

//--- hazard_ctrl.sv
`timescale 1ns/1ns

module hazard_ctrl (
    input  logic              [4:0] rs1,
    input  logic              [4:0] rs2,
    input  logic                    rs1_re,
    input  logic                    rs2_re,
    input  cpu_pkg::id_ex_t         id_ex,
    input  cpu_pkg::ex_mem_t        ex_mem,
    input  cpu_pkg::mem_wb_t        wb,
    input  logic                    mem_wait,
    input  logic                    br_taken,
    output cpu_pkg::fwd_sel_e       fwd1_sel,
    output cpu_pkg::fwd_sel_e       fwd2_sel,
    output logic                    stall_if_id,
    output logic                    hold_all,
    output logic                    flush_young
);
    import cpu_pkg::*;

    logic ex_hit1, ex_hit2, mem_hit1, mem_hit2, wb_hit1, wb_hit2;

    function automatic logic hit(input logic v, input logic we,
                                 input logic [4:0] dst, input logic [4:0] src);
        return v && we && (dst != 5'd0) && (dst == src);
    endfunction

    // youngest writer wins
    function automatic fwd_sel_e pick(input logic e, input logic m, input logic w);
        if (e)
            return FWD_EX;
        else if (m)
            return FWD_MEM;
        else if (w)
            return FWD_WB;
        return FWD_RF;
    endfunction

    assign ex_hit1  = hit(id_ex.valid, id_ex.ctrl.reg_write, id_ex.ctrl.rd, rs1);
    assign ex_hit2  = hit(id_ex.valid, id_ex.ctrl.reg_write, id_ex.ctrl.rd, rs2);
    assign mem_hit1 = hit(ex_mem.valid, ex_mem.write, ex_mem.rd, rs1);
    assign mem_hit2 = hit(ex_mem.valid, ex_mem.write, ex_mem.rd, rs2);
    assign wb_hit1  = hit(wb.valid, wb.write, wb.rd, rs1);
    assign wb_hit2  = hit(wb.valid, wb.write, wb.rd, rs2);

    assign fwd1_sel = pick(ex_hit1, mem_hit1, wb_hit1);
    assign fwd2_sel = pick(ex_hit2, mem_hit2, wb_hit2);

    // load data not ready in EX, wait one cycle and take it from MEM
    assign stall_if_id = id_ex.ctrl.load && ((rs1_re && ex_hit1) || (rs2_re && ex_hit2));
    assign hold_all    = mem_wait;
    assign flush_young = br_taken && !hold_all;

    // EX holds either a load or a branch, never both
    always_comb begin
        a_no_stall_flush: assert final (!(stall_if_id && flush_young));
    end

endmodule

//--- mem_unit.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module mem_unit (
    input  logic             cpu_clk,
    input  logic             cpu_rstn,
    input  cpu_pkg::ex_mem_t ex_mem,
    input  logic             hold,
    output logic [3:0]       daccess_ren,
    output logic [3:0]       daccess_wen,
    output logic [`XLEN-1:0] daccess_addr,
    output logic [`XLEN-1:0] daccess_wdata,
    input  logic             daccess_valid,
    input  logic [`XLEN-1:0] daccess_rdata,
    input  logic             daccess_wresp,
    output logic             mem_wait,
    output logic [`XLEN-1:0] mem_fwd,
    output cpu_pkg::mem_wb_t wb,
    output logic [`XLEN-1:0] debug_wb_pc,
    output logic [3:0]       debug_wb_ena,
    output logic [4:0]       debug_wb_reg,
    output logic [`XLEN-1:0] debug_wb_value
);

    logic is_ld, is_st;

    // misaligned accesses already lost load/store in EX
    assign is_ld = ex_mem.valid && ex_mem.load;
    assign is_st = ex_mem.valid && ex_mem.store;

    assign daccess_ren   = {4{is_ld}};      // word only
    assign daccess_wen   = {4{is_st}};
    assign daccess_addr  = ex_mem.result;
    assign daccess_wdata = ex_mem.sdata;

    // request held until its single-cycle response
    assign mem_wait = (is_ld && !daccess_valid) || (is_st && !daccess_wresp);

    assign mem_fwd = ex_mem.load ? daccess_rdata : ex_mem.result;

    // WB drains to a bubble while MEM waits, so each entry retires once
    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            wb <= '0;
        end else if (hold) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex_mem.valid;
            wb.pc    <= ex_mem.pc;
            wb.write <= ex_mem.write;
            wb.rd    <= ex_mem.rd;
            wb.data  <= mem_fwd;
        end
    end

    assign debug_wb_pc    = wb.pc;
    assign debug_wb_ena   = {4{wb.valid && wb.write && wb.rd != 5'd0}};   // r0 not reported
    assign debug_wb_reg   = wb.rd;
    assign debug_wb_value = wb.data;

    a_req_stable: assert property (
        @(posedge cpu_clk) disable iff (!cpu_rstn)
        mem_wait |=> $stable(daccess_ren) && $stable(daccess_wen)
                     && $stable(daccess_addr) && $stable(daccess_wdata));

endmodule

//--- execute_unit.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module execute_unit (
    input  logic             cpu_clk,
    input  logic             cpu_rstn,
    input  cpu_pkg::id_ex_t  id_ex,
    input  logic             hold,
    output logic             br_taken,
    output logic [`XLEN-1:0] br_target,
    output logic [`XLEN-1:0] ex_fwd,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] b, result;
    logic             misalign;     // word access with low bits set
    logic             eq;

    assign b = id_ex.ctrl.b_imm ? id_ex.imm : id_ex.op2;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    result = id_ex.op1 - b;
            ALU_AND:    result = id_ex.op1 & b;
            ALU_OR:     result = id_ex.op1 | b;
            ALU_XOR:    result = id_ex.op1 ^ b;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(id_ex.op1) < $signed(b)};
            ALU_PASS_B: result = b;                     // lu12i.w
            default:    result = id_ex.op1 + b;         // add, addi, address
        endcase
    end

    assign ex_fwd = result;

    // beq/bne compare rj with rd, both in op1/op2
    assign eq = (id_ex.op1 == id_ex.op2);
    always_comb begin
        case (id_ex.ctrl.br_kind)
            BR_EQ:     br_taken = id_ex.valid && eq;
            BR_NE:     br_taken = id_ex.valid && !eq;
            BR_ALWAYS: br_taken = id_ex.valid;
            default:   br_taken = 1'b0;
        endcase
    end
    assign br_target = id_ex.pc + id_ex.imm;

    assign misalign = (id_ex.ctrl.load || id_ex.ctrl.store) && (result[1:0] != 2'b00);

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            ex_mem <= '0;
        end else if (!hold) begin
            ex_mem.valid  <= id_ex.valid;
            ex_mem.pc     <= id_ex.pc;
            ex_mem.write  <= id_ex.valid && id_ex.ctrl.reg_write && !misalign;
            ex_mem.load   <= id_ex.valid && id_ex.ctrl.load && !misalign;
            ex_mem.store  <= id_ex.valid && id_ex.ctrl.store && !misalign;
            ex_mem.rd     <= id_ex.ctrl.rd;
            ex_mem.result <= result;
            ex_mem.sdata  <= id_ex.op2;
        end
    end

    // a redirect comes from a real branch, which writes nothing
    a_br_valid: assert property (
        @(posedge cpu_clk) disable iff (!cpu_rstn)
        br_taken |-> id_ex.valid && !id_ex.ctrl.reg_write
                     && !id_ex.ctrl.load && !id_ex.ctrl.store);

endmodule

//--- decode_unit.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module decode_unit (
    input  logic               cpu_clk,
    input  logic               cpu_rstn,
    input  logic               if_id_valid,
    input  logic [`XLEN-1:0]   if_id_pc,
    input  cpu_pkg::inst_u     if_id_inst,
    input  logic               stall,
    input  logic               hold,
    input  logic               flush,
    input  cpu_pkg::fwd_sel_e  fwd1_sel,
    input  cpu_pkg::fwd_sel_e  fwd2_sel,
    input  logic [`XLEN-1:0]   ex_fwd,
    input  logic [`XLEN-1:0]   mem_fwd,
    input  cpu_pkg::mem_wb_t   wb,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic               rs1_re,
    output logic               rs2_re,
    output cpu_pkg::id_ex_t    id_ex
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] rf [`REG_NUM];    // no reset, r0 masked on read
    logic [`XLEN-1:0] rf_rd1, rf_rd2, op1, op2, imm;
    ctrl_t            ctrl;
    logic             r_type;           // second source is rk
    logic             rj_use;
    logic             rd_use;           // st.w, beq, bne read rd

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] rf_v,
                                                 input logic [`XLEN-1:0] ex_v,
                                                 input logic [`XLEN-1:0] mem_v,
                                                 input logic [`XLEN-1:0] wb_v);
        case (sel)
            FWD_EX:  return ex_v;
            FWD_MEM: return mem_v;
            FWD_WB:  return wb_v;
            default: return rf_v;
        endcase
    endfunction

    always_comb begin
        ctrl    = '0;               // unknown opcode decodes as a no-op
        ctrl.rd = if_id_inst.r.rd;
        r_type  = 1'b0;
        rj_use  = 1'b0;
        rd_use  = 1'b0;
        imm     = {{(`XLEN-12){if_id_inst.i.imm[11]}}, if_id_inst.i.imm};
        case (if_id_inst.r.opcode)
            `OP_ADD_W: begin ctrl.alu_op = ALU_ADD; r_type = 1'b1; end
            `OP_SUB_W: begin ctrl.alu_op = ALU_SUB; r_type = 1'b1; end
            `OP_AND:   begin ctrl.alu_op = ALU_AND; r_type = 1'b1; end
            `OP_OR:    begin ctrl.alu_op = ALU_OR;  r_type = 1'b1; end
            `OP_XOR:   begin ctrl.alu_op = ALU_XOR; r_type = 1'b1; end
            `OP_SLT:   begin ctrl.alu_op = ALU_SLT; r_type = 1'b1; end
            default: ;
        endcase
        ctrl.reg_write = r_type;
        // si12 group, address is rj + si12
        case (if_id_inst.i.opcode)
            `OP_ADDI_W: begin ctrl.b_imm = 1'b1; ctrl.reg_write = 1'b1; rj_use = 1'b1; end
            `OP_LD_W: begin
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.load      = 1'b1;
                rj_use         = 1'b1;
            end
            `OP_ST_W: begin
                ctrl.b_imm = 1'b1;
                ctrl.store = 1'b1;
                rj_use     = 1'b1;
                rd_use     = 1'b1;      // store data
            end
            default: ;
        endcase
        if (if_id_inst.r.opcode[16:10] == `OP_LU12I_W) begin
            ctrl.alu_op    = ALU_PASS_B;
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            imm = {if_id_inst.r.opcode[9:0], if_id_inst.r.rk, if_id_inst.r.rj, 12'd0};
        end
        // offs16 sits in [25:10], offs26 adds [9:0] on top
        case (if_id_inst.r.opcode[16:11])
            `OP_BEQ, `OP_BNE: begin
                ctrl.br_kind = (if_id_inst.r.opcode[11]) ? BR_NE : BR_EQ;
                rj_use       = 1'b1;
                rd_use       = 1'b1;
                imm = {{(`XLEN-18){if_id_inst.r.opcode[10]}},
                       if_id_inst.r.opcode[10:0], if_id_inst.r.rk, 2'b00};
            end
            `OP_B: begin
                ctrl.br_kind = BR_ALWAYS;
                imm = {{(`XLEN-28){if_id_inst.r.rj[4]}}, if_id_inst.r.rj, if_id_inst.r.rd,
                       if_id_inst.r.opcode[10:0], if_id_inst.r.rk, 2'b00};
            end
            default: ;
        endcase
    end

    assign rs1    = if_id_inst.r.rj;
    assign rs2    = r_type ? if_id_inst.r.rk : if_id_inst.r.rd;
    assign rs1_re = if_id_valid && (r_type || rj_use);
    assign rs2_re = if_id_valid && (r_type || rd_use);

    // same-cycle WB write is covered by the WB forward
    assign rf_rd1 = (rs1 == 5'd0) ? '0 : rf[rs1];
    assign rf_rd2 = (rs2 == 5'd0) ? '0 : rf[rs2];
    assign op1    = fwd_mux(fwd1_sel, rf_rd1, ex_fwd, mem_fwd, wb.data);
    assign op2    = fwd_mux(fwd2_sel, rf_rd2, ex_fwd, mem_fwd, wb.data);

    always_ff @(posedge cpu_clk) begin
        if (wb.valid && wb.write && wb.rd != 5'd0)
            rf[wb.rd] <= wb.data;
    end

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            id_ex <= '0;
        end else if (!hold) begin
            if (stall || flush) begin
                id_ex <= '0;            // bubble
            end else begin
                id_ex.valid <= if_id_valid;
                id_ex.pc    <= if_id_pc;
                id_ex.ctrl  <= ctrl;
                id_ex.op1   <= op1;
                id_ex.op2   <= op2;
                id_ex.imm   <= imm;
            end
        end
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module fetch_unit (
    input  logic             cpu_clk,
    input  logic             cpu_rstn,
    input  logic             stall,
    input  logic             hold,
    input  logic             flush,
    input  logic             br_taken,
    input  logic [`XLEN-1:0] br_target,
    input  logic [`XLEN-1:0] ifetch_inst,
    output logic             ifetch_rreq,
    output logic [`XLEN-1:0] ifetch_addr,
    output logic             if_id_valid,
    output logic [`XLEN-1:0] if_id_pc,
    output cpu_pkg::inst_u   if_id_inst
);

    logic             fetch_on;     // low through reset, then stays high
    logic [`XLEN-1:0] pc;

    assign ifetch_rreq = fetch_on && !stall && !hold;
    assign ifetch_addr = pc;        // inst comes back in the same cycle

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn)
            fetch_on <= 1'b0;
        else
            fetch_on <= 1'b1;
    end

    // not-taken prediction, EX redirect wins
    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            pc <= `CPU_RESET_PC;
        end else if (!hold) begin
            if (br_taken)
                pc <= br_target;
            else if (fetch_on && !stall)
                pc <= pc + `XLEN'd4;
        end
    end

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            if_id_valid <= 1'b0;
        end else if (!hold) begin
            if (flush)
                if_id_valid <= 1'b0;      // wrong-path fetch dropped
            else if (!stall)
                if_id_valid <= fetch_on;
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!hold && !flush && !stall) begin
            if_id_pc   <= pc;
            if_id_inst <= ifetch_inst;
        end
    end

    // branch targets come from EX, must stay word aligned
    a_pc_aligned: assert property (
        @(posedge cpu_clk) disable iff (!cpu_rstn) pc[1:0] == 2'b00);

endmodule

//--- cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // rd, rj, rk with a 17-bit opcode
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r_fmt_t;

    // si12 form, used by addi.w, ld.w and st.w
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_ALWAYS} br_kind_e;

    typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       b_imm;      // operand b from immediate
        logic       reg_write;
        logic       load;
        logic       store;
        br_kind_e   br_kind;
        logic [4:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        ctrl_t            ctrl;
        logic [`XLEN-1:0] op1;
        logic [`XLEN-1:0] op2;      // rk, or rd for st.w and branches
        logic [`XLEN-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic             write;
        logic             load;
        logic             store;
        logic [4:0]       rd;
        logic [`XLEN-1:0] result;   // alu result or data address
        logic [`XLEN-1:0] sdata;
    } ex_mem_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic             write;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } mem_wb_t;

endpackage

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first fetch address after reset
`define CPU_RESET_PC    32'h1c00_0000

`define XLEN            32      // data and address width
`define REG_NUM         32      // general registers, r0 reads zero

// register format, bits [31:15]
`define OP_ADD_W        17'h00020
`define OP_SUB_W        17'h00022
`define OP_SLT          17'h00024
`define OP_AND          17'h00029
`define OP_OR           17'h0002a
`define OP_XOR          17'h0002b

// 12-bit immediate format, bits [31:22]
`define OP_ADDI_W       10'h00a
`define OP_LD_W         10'h0a2
`define OP_ST_W         10'h0a6

// 20-bit immediate, bits [31:25]
`define OP_LU12I_W      7'h0a

// branches, bits [31:26]
`define OP_B            6'h14
`define OP_BEQ          6'h16
`define OP_BNE          6'h17

`endif
